// File: logic/sigma_tile_pkg.sv
// sigma tile package with bus widths, the register map and interrupt line numbers
package sigma_tile_pkg;

    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;
    localparam int BUS_BE_W   = 4;

    typedef logic [BUS_DATA_W-1:0] word_t;
    typedef logic [BUS_ADDR_W-1:0] addr_t;
    typedef logic [BUS_BE_W-1:0]   be_t;

    // address bit that moves an access from RAM to the register block
    localparam int SFR_BITSEL = 20;

    // register word offsets, addr[4:2]
    localparam logic [2:0] SFR_CORE_ID      = 3'd0;
    localparam logic [2:0] SFR_CTRL         = 3'd1;
    localparam logic [2:0] SFR_IRQ_EN       = 3'd2;
    localparam logic [2:0] SFR_TIMER_PERIOD = 3'd3;
    localparam logic [2:0] SFR_TIMER_VALUE  = 3'd4;
    localparam logic [2:0] SFR_SGI          = 3'd5;

    // line driven by the periodic timer
    localparam int TIMER_IRQ_LINE = 1;

endpackage

// File: logic/host_bus_decoder.sv
// host bus decoder, splits host accesses between data RAM and registers and merges read data
`timescale 1ns/1ps

module host_bus_decoder
#(
    parameter int MEM_WORDS = 1024
)
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic                              hif_req_i,
    input  logic                              hif_we_i,
    input  sigma_tile_pkg::addr_t             hif_addr_i,
    input  sigma_tile_pkg::be_t               hif_be_i,
    input  sigma_tile_pkg::word_t             hif_wdata_i,
    output logic                              hif_ack_o,
    output logic                              hif_resp_o,
    output sigma_tile_pkg::word_t             hif_rdata_o,

    output logic                              ram_req_o,
    output logic                              ram_we_o,
    output logic [$clog2(MEM_WORDS)-1:0]      ram_addr_o,
    output sigma_tile_pkg::be_t               ram_be_o,
    output sigma_tile_pkg::word_t             ram_wdata_o,
    input  logic                              ram_resp_i,
    input  sigma_tile_pkg::word_t             ram_rdata_i,

    output logic                              sfr_req_o,
    output logic                              sfr_we_o,
    output logic [2:0]                        sfr_addr_o,
    output sigma_tile_pkg::word_t             sfr_wdata_o,
    input  logic                              sfr_resp_i,
    input  sigma_tile_pkg::word_t             sfr_rdata_i
);

    localparam int RAM_AW = $clog2(MEM_WORDS);

    logic sfr_hit;
    logic sel_sfr_q;

    // no back-pressure
    assign hif_ack_o = hif_req_i;
    assign sfr_hit   = hif_addr_i[sigma_tile_pkg::SFR_BITSEL];

    assign ram_req_o   = hif_req_i & ~sfr_hit;
    assign ram_we_o    = hif_we_i;
    assign ram_addr_o  = hif_addr_i[RAM_AW+1:2];
    assign ram_be_o    = hif_be_i;
    assign ram_wdata_o = hif_wdata_i;

    assign sfr_req_o   = hif_req_i & sfr_hit;
    assign sfr_we_o    = hif_we_i;
    assign sfr_addr_o  = hif_addr_i[4:2];
    assign sfr_wdata_o = hif_wdata_i;

    // both targets answer one cycle later, so last read's target picks the response
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            sel_sfr_q <= 1'b0;
        else if (hif_req_i && !hif_we_i)
            sel_sfr_q <= sfr_hit;
    end

    assign hif_resp_o  = sel_sfr_q ? sfr_resp_i : ram_resp_i;
    assign hif_rdata_o = sel_sfr_q ? sfr_rdata_i : ram_rdata_i;

endmodule

// File: logic/data_ram.sv
// data RAM, single-port word memory with byte-enable writes and registered read response
`timescale 1ns/1ps

module data_ram
#(
    parameter int MEM_WORDS = 1024
)
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [$clog2(MEM_WORDS)-1:0]  addr_i,
    input  sigma_tile_pkg::be_t           be_i,
    input  sigma_tile_pkg::word_t         wdata_i,
    output logic                          resp_o,
    output sigma_tile_pkg::word_t         rdata_o
);

    sigma_tile_pkg::word_t mem [MEM_WORDS];

    always_ff @(posedge clk_i)
    begin
        if (req_i && we_i)
        begin
            for (int i = 0; i < sigma_tile_pkg::BUS_BE_W; i++)
            begin
                if (be_i[i])
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
            end
        end
        if (req_i && !we_i)
            rdata_o <= mem[addr_i];
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            resp_o <= 1'b0;
        else
            resp_o <= req_i && !we_i;
    end

endmodule

// File: logic/sfr_regs.sv
// special function registers: core id, soft reset, interrupt mask, timer and software interrupts
`timescale 1ns/1ps

module sfr_regs
#(
    parameter int CORE_ID          = 0,
    parameter int IRQ_NUM_POW      = 4,
    parameter bit SW_RESET_DEFAULT = 1'b0
)
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [2:0]                    addr_i,
    input  sigma_tile_pkg::word_t         wdata_i,
    output logic                          resp_o,
    output sigma_tile_pkg::word_t         rdata_o,
    output logic                          sw_reset_o,
    output logic [(2**IRQ_NUM_POW)-1:0]   irq_en_o,
    output logic                          timer_tick_o,
    output logic                          sgi_req_o,
    output logic [IRQ_NUM_POW-1:0]        sgi_code_o
);

    sigma_tile_pkg::word_t timer_period_q;
    sigma_tile_pkg::word_t timer_value_q;

    logic wr_en;
    logic rd_en;

    assign wr_en = req_i & we_i;
    assign rd_en = req_i & ~we_i;

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            sw_reset_o     <= SW_RESET_DEFAULT;
            irq_en_o       <= '0;
            timer_period_q <= '0;
            timer_value_q  <= '0;
            timer_tick_o   <= 1'b0;
            sgi_req_o      <= 1'b0;
            resp_o         <= 1'b0;
        end
        else
        begin
            resp_o    <= rd_en;
            sgi_req_o <= wr_en && (addr_i == sigma_tile_pkg::SFR_SGI);

            if (wr_en)
            begin
                case (addr_i)
                    sigma_tile_pkg::SFR_CTRL:         sw_reset_o <= wdata_i[0];
                    sigma_tile_pkg::SFR_IRQ_EN:       irq_en_o <= wdata_i[(2**IRQ_NUM_POW)-1:0];
                    sigma_tile_pkg::SFR_TIMER_PERIOD: timer_period_q <= wdata_i;
                    default:                          ;
                endcase
            end

            // wraps after period+1 cycles, also catches a period lowered below the count
            timer_tick_o <= 1'b0;
            if (timer_period_q == '0)
                timer_value_q <= '0;
            else if (timer_value_q >= timer_period_q)
            begin
                timer_value_q <= '0;
                timer_tick_o  <= 1'b1;
            end
            else
                timer_value_q <= timer_value_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_en && (addr_i == sigma_tile_pkg::SFR_SGI))
            sgi_code_o <= wdata_i[IRQ_NUM_POW-1:0];
    end

    // read mux
    always_ff @(posedge clk_i)
    begin
        if (rd_en)
        begin
            case (addr_i)
                sigma_tile_pkg::SFR_CORE_ID:      rdata_o <= sigma_tile_pkg::word_t'(CORE_ID);
                sigma_tile_pkg::SFR_CTRL:         rdata_o <= {31'b0, sw_reset_o};
                sigma_tile_pkg::SFR_IRQ_EN:       rdata_o <= sigma_tile_pkg::word_t'(irq_en_o);
                sigma_tile_pkg::SFR_TIMER_PERIOD: rdata_o <= timer_period_q;
                sigma_tile_pkg::SFR_TIMER_VALUE:  rdata_o <= timer_value_q;
                default:                          rdata_o <= '0;
            endcase
        end
    end

endmodule

// File: logic/irq_adapter.sv
// interrupt adapter, gathers interrupt events and hands them out one at a time with a code
`timescale 1ns/1ps

module irq_adapter
#(
    parameter int IRQ_NUM_POW = 4
)
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [(2**IRQ_NUM_POW)-1:0]   irq_i,
    input  logic [(2**IRQ_NUM_POW)-1:0]   irq_en_i,
    input  logic                          timer_tick_i,
    input  logic                          sgi_req_i,
    input  logic [IRQ_NUM_POW-1:0]        sgi_code_i,
    input  logic                          irq_ack_i,
    output logic                          irq_req_o,
    output logic [IRQ_NUM_POW-1:0]        irq_code_o
);

    localparam int IRQ_NUM = 2**IRQ_NUM_POW;

    logic [IRQ_NUM-1:0]     irq_q;
    logic [IRQ_NUM-1:0]     pending_q;
    logic [IRQ_NUM-1:0]     hw_events;
    logic [IRQ_NUM-1:0]     sgi_events;
    logic [IRQ_NUM-1:0]     pending_clr;
    logic                   pick_valid;
    logic [IRQ_NUM_POW-1:0] pick_code;
    logic                   dispatch;

    // rising edges plus timer, then masked
    assign hw_events = ((irq_i & ~irq_q) | (IRQ_NUM'(timer_tick_i) << sigma_tile_pkg::TIMER_IRQ_LINE))
                       & irq_en_i;
    // software interrupts bypass the mask
    assign sgi_events = sgi_req_i ? (IRQ_NUM'(1) << sgi_code_i) : '0;

    // lowest pending line wins
    always_comb
    begin
        pick_valid = 1'b0;
        pick_code  = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
        begin
            if (pending_q[i])
            begin
                pick_valid = 1'b1;
                pick_code  = IRQ_NUM_POW'(i);
            end
        end
    end

    assign dispatch    = !irq_req_o && pick_valid;
    assign pending_clr = dispatch ? (IRQ_NUM'(1) << pick_code) : '0;

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            irq_q      <= '0;
            pending_q  <= '0;
            irq_req_o  <= 1'b0;
            irq_code_o <= '0;
        end
        else
        begin
            irq_q     <= irq_i;
            pending_q <= (pending_q & ~pending_clr) | hw_events | sgi_events;
            if (dispatch)
            begin
                irq_req_o  <= 1'b1;
                irq_code_o <= pick_code;
            end
            else if (irq_req_o && irq_ack_i)
                irq_req_o <= 1'b0;
        end
    end

endmodule

// File: logic/sigma_tile.sv
// sigma tile top, host bus decoder with data RAM, control registers and interrupt adapter
`timescale 1ns/1ps

module sigma_tile
#(
    parameter int CORE_ID          = 0,
    parameter int MEM_WORDS        = 1024,
    parameter int IRQ_NUM_POW      = 4,
    parameter bit SW_RESET_DEFAULT = 1'b0
)
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          hif_req_i,
    input  logic                          hif_we_i,
    input  sigma_tile_pkg::addr_t         hif_addr_i,
    input  sigma_tile_pkg::be_t           hif_be_i,
    input  sigma_tile_pkg::word_t         hif_wdata_i,
    output logic                          hif_ack_o,
    output logic                          hif_resp_o,
    output sigma_tile_pkg::word_t         hif_rdata_o,

    input  logic [(2**IRQ_NUM_POW)-1:0]   irq_i,
    output logic                          irq_req_o,
    output logic [IRQ_NUM_POW-1:0]        irq_code_o,
    input  logic                          irq_ack_i,

    output logic                          sw_reset_o
);

    localparam int RAM_AW = $clog2(MEM_WORDS);

    logic                        ram_req;
    logic                        ram_we;
    logic [RAM_AW-1:0]           ram_addr;
    sigma_tile_pkg::be_t         ram_be;
    sigma_tile_pkg::word_t       ram_wdata;
    logic                        ram_resp;
    sigma_tile_pkg::word_t       ram_rdata;

    logic                        sfr_req;
    logic                        sfr_we;
    logic [2:0]                  sfr_addr;
    sigma_tile_pkg::word_t       sfr_wdata;
    logic                        sfr_resp;
    sigma_tile_pkg::word_t       sfr_rdata;

    logic [(2**IRQ_NUM_POW)-1:0] irq_en;
    logic                        timer_tick;
    logic                        sgi_req;
    logic [IRQ_NUM_POW-1:0]      sgi_code;
    logic                        irq_rst_n;

    // soft reset also holds the interrupt logic
    assign irq_rst_n = rst_n_i & ~sw_reset_o;

    host_bus_decoder #(
        .MEM_WORDS(MEM_WORDS)
    ) u_host_bus_decoder (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .hif_req_i(hif_req_i), .hif_we_i(hif_we_i), .hif_addr_i(hif_addr_i),
        .hif_be_i(hif_be_i), .hif_wdata_i(hif_wdata_i),
        .hif_ack_o(hif_ack_o), .hif_resp_o(hif_resp_o), .hif_rdata_o(hif_rdata_o),
        .ram_req_o(ram_req), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
        .ram_be_o(ram_be), .ram_wdata_o(ram_wdata),
        .ram_resp_i(ram_resp), .ram_rdata_i(ram_rdata),
        .sfr_req_o(sfr_req), .sfr_we_o(sfr_we), .sfr_addr_o(sfr_addr),
        .sfr_wdata_o(sfr_wdata), .sfr_resp_i(sfr_resp), .sfr_rdata_i(sfr_rdata)
    );

    data_ram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_data_ram (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .req_i(ram_req), .we_i(ram_we), .addr_i(ram_addr), .be_i(ram_be),
        .wdata_i(ram_wdata), .resp_o(ram_resp), .rdata_o(ram_rdata)
    );

    sfr_regs #(
        .CORE_ID(CORE_ID), .IRQ_NUM_POW(IRQ_NUM_POW), .SW_RESET_DEFAULT(SW_RESET_DEFAULT)
    ) u_sfr_regs (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .req_i(sfr_req), .we_i(sfr_we), .addr_i(sfr_addr), .wdata_i(sfr_wdata),
        .resp_o(sfr_resp), .rdata_o(sfr_rdata), .sw_reset_o(sw_reset_o),
        .irq_en_o(irq_en), .timer_tick_o(timer_tick),
        .sgi_req_o(sgi_req), .sgi_code_o(sgi_code)
    );

    irq_adapter #(
        .IRQ_NUM_POW(IRQ_NUM_POW)
    ) u_irq_adapter (
        .clk_i(clk_i), .rst_n_i(irq_rst_n),
        .irq_i(irq_i), .irq_en_i(irq_en), .timer_tick_i(timer_tick),
        .sgi_req_i(sgi_req), .sgi_code_i(sgi_code), .irq_ack_i(irq_ack_i),
        .irq_req_o(irq_req_o), .irq_code_o(irq_code_o)
    );

endmodule

// File: verification/sigma_tile_checker.sv
// sigma tile checker, compares read data, taken interrupt codes and soft reset with expected values
`timescale 1ns/1ps

module sigma_tile_checker
#(
    parameter int IRQ_NUM_POW = 4
)
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   hif_req_i,
    input  logic                   hif_we_i,
    input  logic                   hif_ack_i,
    input  logic                   hif_resp_i,
    input  sigma_tile_pkg::word_t  hif_rdata_i,
    input  logic                   irq_req_i,
    input  logic [IRQ_NUM_POW-1:0] irq_code_i,
    input  logic                   irq_ack_i,
    input  logic                   sw_reset_i
);

    sigma_tile_pkg::word_t  read_exp_q[$];
    bit                     read_max_q[$];
    logic [IRQ_NUM_POW-1:0] code_exp_q[$];
    logic                   read_issued_q;
    logic                   irq_taken_q;
    logic                   sw_reset_q;
    int                     errors = 0;
    int                     checks = 0;

    task automatic expect_read(input sigma_tile_pkg::word_t value, input bit is_max);
        read_exp_q.push_back(value);
        read_max_q.push_back(is_max);
    endtask

    task automatic expect_irq(input logic [IRQ_NUM_POW-1:0] code);
        code_exp_q.push_back(code);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_sw_reset(input logic value);
        checks++;
        if (sw_reset_i !== value)
        begin
            errors++;
            $display("MISMATCH at %0t: sw_reset_o is %b, expected %b", $time, sw_reset_i, value);
        end
    endtask

    function automatic int reads_outstanding();
        return read_exp_q.size();
    endfunction

    // sampled at the rising edge, before the DUT registers update
    always @(posedge clk_i)
    begin : sample
        sigma_tile_pkg::word_t  exp_val;
        bit                     is_max;
        logic [IRQ_NUM_POW-1:0] exp_code;
        if (!rst_n_i)
        begin
            read_issued_q <= 1'b0;
            irq_taken_q   <= 1'b0;
            sw_reset_q    <= 1'b0;
        end
        else
        begin
            read_issued_q <= hif_req_i && hif_ack_i && !hif_we_i;
            irq_taken_q   <= irq_req_i && irq_ack_i;
            sw_reset_q    <= sw_reset_i;
            // the tile never stalls the host
            if (hif_ack_i !== hif_req_i)
            begin
                errors++;
                $display("MISMATCH at %0t: hif_ack_o is %b, hif_req_i is %b", $time,
                         hif_ack_i, hif_req_i);
            end
            if (hif_resp_i !== read_issued_q)
                note_failure($sformatf("read response %b, but read accepted a cycle earlier %b",
                                       hif_resp_i, read_issued_q));
            if (hif_resp_i === 1'b1)
            begin
                if (read_exp_q.size() == 0)
                    note_failure("read response arrived with no read outstanding");
                else
                begin
                    exp_val = read_exp_q.pop_front();
                    is_max  = read_max_q.pop_front();
                    checks++;
                    if ($isunknown(hif_rdata_i) ||
                        (is_max ? (hif_rdata_i > exp_val) : (hif_rdata_i != exp_val)))
                    begin
                        errors++;
                        $display("MISMATCH at %0t: read data %h, expected %s%h", $time,
                                 hif_rdata_i, is_max ? "at most " : "", exp_val);
                    end
                end
            end
            // interrupt taken
            if (irq_req_i && irq_ack_i)
            begin
                if (code_exp_q.size() == 0)
                    note_failure("interrupt taken while none was expected");
                else
                begin
                    exp_code = code_exp_q.pop_front();
                    checks++;
                    if (irq_code_i !== exp_code)
                    begin
                        errors++;
                        $display("MISMATCH at %0t: interrupt code %0d, expected %0d", $time,
                                 irq_code_i, exp_code);
                    end
                end
            end
            if (irq_taken_q && irq_req_i !== 1'b0)
                note_failure("interrupt request still high after acknowledge");
            if (sw_reset_q && sw_reset_i && irq_req_i)
                note_failure("interrupt request raised while soft reset is set");
        end
    end

endmodule

// File: verification/sigma_tile_tb.sv
// sigma tile testbench, applies a table of host accesses and interrupt events to the tile
`timescale 1ns/1ps

module sigma_tile_tb;

    localparam int         IRQ_NUM_POW = 4;
    localparam int         TIMEOUT     = 200;
    localparam logic [3:0] K_WRITE     = 4'd0;
    localparam logic [3:0] K_READ      = 4'd1;
    localparam logic [3:0] K_READ_MAX  = 4'd2;
    localparam logic [3:0] K_PULSE     = 4'd3;
    localparam logic [3:0] K_EXPECT    = 4'd4;
    localparam logic [3:0] K_SW_RESET  = 4'd5;
    localparam logic [3:0] K_IDLE      = 4'd6;

    typedef struct packed {
        logic [3:0]            kind;
        logic [3:0]            test;
        sigma_tile_pkg::addr_t addr;
        sigma_tile_pkg::be_t   be;
        sigma_tile_pkg::word_t data;
        sigma_tile_pkg::word_t expv;
    } row_t;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        hif_req;
    logic                        hif_we;
    sigma_tile_pkg::addr_t       hif_addr;
    sigma_tile_pkg::be_t         hif_be;
    sigma_tile_pkg::word_t       hif_wdata;
    logic                        hif_ack;
    logic                        hif_resp;
    sigma_tile_pkg::word_t       hif_rdata;
    logic [(2**IRQ_NUM_POW)-1:0] irq;
    logic                        irq_ack;
    logic                        irq_req;
    logic [IRQ_NUM_POW-1:0]      irq_code;
    logic                        sw_reset;
    logic [31:0]                 lfsr_state = 32'h5aae_3223;
    row_t                        rows[$];

    always #10 clk = ~clk;

    sigma_tile #(
        .CORE_ID(3), .MEM_WORDS(256), .IRQ_NUM_POW(IRQ_NUM_POW)
    ) u_sigma_tile (
        .clk_i(clk), .rst_n_i(rst_n),
        .hif_req_i(hif_req), .hif_we_i(hif_we), .hif_addr_i(hif_addr), .hif_be_i(hif_be),
        .hif_wdata_i(hif_wdata), .hif_ack_o(hif_ack), .hif_resp_o(hif_resp),
        .hif_rdata_o(hif_rdata), .irq_i(irq), .irq_req_o(irq_req), .irq_code_o(irq_code),
        .irq_ack_i(irq_ack), .sw_reset_o(sw_reset)
    );

    sigma_tile_checker #(
        .IRQ_NUM_POW(IRQ_NUM_POW)
    ) u_checker (
        .clk_i(clk), .rst_n_i(rst_n), .hif_req_i(hif_req), .hif_we_i(hif_we),
        .hif_ack_i(hif_ack), .hif_resp_i(hif_resp), .hif_rdata_i(hif_rdata),
        .irq_req_i(irq_req), .irq_code_i(irq_code), .irq_ack_i(irq_ack), .sw_reset_i(sw_reset)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic sigma_tile_pkg::addr_t sfr_addr(input logic [2:0] offset);
        return (sigma_tile_pkg::addr_t'(1) << sigma_tile_pkg::SFR_BITSEL) | {offset, 2'b00};
    endfunction

    function automatic string test_name(input int test);
        case (test)
            1:       return "ram byte enables";
            2:       return "back-to-back reads";
            3:       return "register access and soft reset";
            4:       return "software interrupt";
            5:       return "external interrupts";
            default: return "timer interrupt";
        endcase
    endfunction

    task automatic add_row(input logic [3:0] test, input logic [3:0] kind,
                           input sigma_tile_pkg::addr_t addr, input sigma_tile_pkg::be_t be,
                           input sigma_tile_pkg::word_t data, input sigma_tile_pkg::word_t expv);
        rows.push_back({kind, test, addr, be, data, expv});
    endtask

    task automatic build_table();
        sigma_tile_pkg::word_t vals[8];
        sigma_tile_pkg::word_t w;
        // second write replaces bytes 0 and 2 only
        add_row(1, K_WRITE, 32'h40, 4'hf, 32'h1122_3344, 0);
        add_row(1, K_WRITE, 32'h40, 4'h5, 32'haabb_ccdd, 0);
        add_row(1, K_READ, 32'h40, 4'hf, 0, 32'h11bb_33dd);
        for (int i = 0; i < 8; i++)
        begin
            w = '0;
            for (int b = 0; b < 32; b++)
            begin
                lfsr_state = lfsr_step(lfsr_state);
                w = {w[30:0], lfsr_state[0]};
            end
            vals[i] = w;
            add_row(2, K_WRITE, 32'h100 + 4 * i, 4'hf, w, 0);
        end
        for (int i = 0; i < 8; i++)
            add_row(2, K_READ, 32'h100 + 4 * i, 4'hf, 0, vals[i]);
        add_row(3, K_SW_RESET, 0, 0, 0, 0);
        add_row(3, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 4'hf, 32'h3c21, 0);
        add_row(3, K_READ, sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 4'hf, 0, 32'h3c21);
        add_row(3, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_TIMER_PERIOD), 4'hf, 32'h1234, 0);
        add_row(3, K_READ, sfr_addr(sigma_tile_pkg::SFR_TIMER_PERIOD), 4'hf, 0, 32'h1234);
        add_row(3, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_TIMER_PERIOD), 4'hf, 0, 0);
        add_row(3, K_READ, sfr_addr(sigma_tile_pkg::SFR_CORE_ID), 4'hf, 0, 3);
        add_row(3, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_CTRL), 4'hf, 1, 0);
        add_row(3, K_SW_RESET, 0, 0, 0, 1);
        // held in soft reset, this one must not come out
        add_row(3, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_SGI), 4'hf, 3, 0);
        add_row(3, K_IDLE, 0, 0, 12, 0);
        add_row(3, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_CTRL), 4'hf, 0, 0);
        add_row(3, K_SW_RESET, 0, 0, 0, 0);
        add_row(3, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_SGI), 4'hf, 4, 0);
        add_row(3, K_EXPECT, 0, 0, 0, 4);
        // line 9 is masked off by 0x3c21
        add_row(4, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_SGI), 4'hf, 9, 0);
        add_row(4, K_EXPECT, 0, 0, 0, 9);
        add_row(5, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 4'hf, 32'h20, 0);
        add_row(5, K_PULSE, 0, 0, 32'ha0, 0);
        add_row(5, K_EXPECT, 0, 0, 0, 5);
        add_row(5, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 4'hf, 32'h44, 0);
        add_row(5, K_PULSE, 0, 0, 32'h44, 0);
        add_row(5, K_EXPECT, 0, 0, 0, 2);
        add_row(5, K_EXPECT, 0, 0, 0, 6);
        add_row(6, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_TIMER_PERIOD), 4'hf, 20, 0);
        add_row(6, K_WRITE, sfr_addr(sigma_tile_pkg::SFR_IRQ_EN), 4'hf,
                32'h1 << sigma_tile_pkg::TIMER_IRQ_LINE, 0);
        for (int i = 0; i < 2; i++)
        begin
            add_row(6, K_EXPECT, 0, 0, 0, sigma_tile_pkg::TIMER_IRQ_LINE);
            add_row(6, K_READ_MAX, sfr_addr(sigma_tile_pkg::SFR_TIMER_VALUE), 4'hf, 0, 20);
        end
    endtask

    task automatic drive_idle();
        hif_req   = 1'b0;
        hif_we    = 1'b0;
        hif_addr  = '0;
        hif_be    = '0;
        hif_wdata = '0;
        irq       = '0;
    endtask

    task automatic take_irq(input logic [IRQ_NUM_POW-1:0] code);
        int cnt;
        cnt = 0;
        while (!irq_req && cnt < TIMEOUT)
        begin
            @(negedge clk);
            cnt++;
        end
        if (!irq_req)
            u_checker.note_failure($sformatf("no interrupt request for code %0d within %0d cycles",
                                             code, TIMEOUT));
        else
        begin
            u_checker.expect_irq(code);
            irq_ack = 1'b1;
            @(negedge clk);
            irq_ack = 1'b0;
        end
    endtask

    task automatic apply_row(input row_t r);
        drive_idle();
        case (r.kind)
            K_WRITE, K_READ, K_READ_MAX:
            begin
                hif_req   = 1'b1;
                hif_we    = (r.kind == K_WRITE);
                hif_addr  = r.addr;
                hif_be    = r.be;
                hif_wdata = r.data;
                if (r.kind != K_WRITE)
                    u_checker.expect_read(r.expv, r.kind == K_READ_MAX);
                @(negedge clk);
            end
            K_PULSE:
            begin
                irq = r.data[(2**IRQ_NUM_POW)-1:0];
                @(negedge clk);
            end
            K_SW_RESET:
                u_checker.check_sw_reset(r.expv[0]);
            K_IDLE:
                repeat (r.data) @(negedge clk);
            K_EXPECT:
                take_irq(r.expv[IRQ_NUM_POW-1:0]);
            default:
                u_checker.note_failure("unknown row kind in the stimulus table");
        endcase
    endtask

    task automatic finish_test(input int test, input int errors_before);
        int cnt;
        drive_idle();
        cnt = 0;
        while (u_checker.reads_outstanding() > 0 && cnt < TIMEOUT)
        begin
            @(negedge clk);
            cnt++;
        end
        if (u_checker.reads_outstanding() > 0)
            u_checker.note_failure("read responses still missing at the end of the test");
        $display("test %0d %s: %s", test, test_name(test),
                 (u_checker.errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial
    begin : main
        int test_now;
        int errors_before;
        int tests_run;
        drive_idle();
        irq_ack = 1'b0;
        rst_n   = 1'b0;
        build_table();
        repeat (5) @(negedge clk);
        rst_n         = 1'b1;
        test_now      = rows[0].test;
        errors_before = 0;
        tests_run     = 0;
        foreach (rows[i])
        begin
            if (rows[i].test != test_now)
            begin
                finish_test(test_now, errors_before);
                tests_run++;
                test_now      = rows[i].test;
                errors_before = u_checker.errors;
            end
            apply_row(rows[i]);
        end
        finish_test(test_now, errors_before);
        tests_run++;
        $display("tests %0d, checks %0d, errors %0d", tests_run, u_checker.checks,
                 u_checker.errors);
        if (u_checker.errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: sigma_tile.f
logic/sigma_tile_pkg.sv
logic/host_bus_decoder.sv
logic/data_ram.sv
logic/sfr_regs.sv
logic/irq_adapter.sv
logic/sigma_tile.sv
verification/sigma_tile_checker.sv
verification/sigma_tile_tb.sv

// File: Bender.yml
package:
  name: sigma_tile

sources:
  - logic/sigma_tile_pkg.sv
  - logic/host_bus_decoder.sv
  - logic/data_ram.sv
  - logic/sfr_regs.sv
  - logic/irq_adapter.sv
  - logic/sigma_tile.sv
  - target: test
    files:
      - verification/sigma_tile_checker.sv
      - verification/sigma_tile_tb.sv
